//--- hw/cpu_defs.svh
/* core-wide constants, macros only
   word width also sets the data port and address width
   REG_COUNT must stay a power of two */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// datapath and address width
`define CPU_WORD 32

// architectural registers, r0 reads zero
`define REG_COUNT 32

// first fetch address after rst
`define RESET_PC 32'h0000_0000

// byte step per instruction, no compressed encodings
`define PC_STEP 32'd4

`endif

//--- hw/cpu_types_pkg.sv
/* shared types for the core and its testbench
   opcode and funct encodings follow the MIPS fields; HALT is opcode 6'h3f
   LL and SC decode without any link semantics */
`include "cpu_defs.svh"

package cpu_types_pkg;

   typedef logic [$clog2(`REG_COUNT)-1:0] regbits_t; // register index

   // primary opcode, bits 31:26
   typedef enum logic [5:0] {
      RTYPE = 6'b000000,
      J     = 6'b000010,
      JAL   = 6'b000011,
      BEQ   = 6'b000100,
      BNE   = 6'b000101,
      ADDIU = 6'b001001,
      SLTI  = 6'b001010,
      SLTIU = 6'b001011,
      ANDI  = 6'b001100,
      ORI   = 6'b001101,
      XORI  = 6'b001110,
      LUI   = 6'b001111,
      LW    = 6'b100011,
      SW    = 6'b101011,
      LL    = 6'b110000,
      SC    = 6'b111000,
      HALT  = 6'b111111
   } opcode_t;

   // r-type function, bits 5:0
   typedef enum logic [5:0] {
      SLL  = 6'b000000,
      SRL  = 6'b000010,
      JR   = 6'b001000,
      ADD  = 6'b100000,
      ADDU = 6'b100001,
      SUB  = 6'b100010,
      SUBU = 6'b100011,
      AND  = 6'b100100,
      OR   = 6'b100101,
      XOR  = 6'b100110,
      NOR  = 6'b100111,
      SLT  = 6'b101010,
      SLTU = 6'b101011
   } funct_t;

   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
      ALU_NOR, ALU_SLL, ALU_SRL, ALU_SLT, ALU_SLTU
   } alu_op_t;

   typedef enum logic [1:0] {
      FETCH, EXEC, MEM, HALTED
   } cpu_state_t;

   typedef struct packed {
      regbits_t    rs;
      regbits_t    rt;
      regbits_t    rd;
      logic [4:0]  shamt;
      logic [15:0] imm16;
   } instr_fields_t;

   typedef struct packed {
      alu_op_t    alu_op;
      logic [1:0] alu_src;  // 0 reg, 1 ext imm, 2 upper imm
      logic       extop;    // 0 zero-extend, 1 sign-extend
      logic       regdst;   // 1 picks rt
      logic       regwr;
      logic       memwr;
      logic       memtoreg;
      logic       is_mem;   // lw or sw, needs the MEM cycle
      logic [1:0] pc_src;   // 0 step, 1 branch, 2 jump
      logic       jr;
      logic       link;
      logic       halt;
   } ctrl_t;

   // data port request
   typedef struct packed {
      logic [`CPU_WORD-1:0] addr;
      logic [`CPU_WORD-1:0] wdata;
      logic                 ren;
      logic                 wen;
   } dmem_req_t;

   // one observed store
   typedef struct packed {
      logic [`CPU_WORD-1:0] addr;
      logic [`CPU_WORD-1:0] data;
   } dmem_write_t;

endpackage

//--- hw/control_unit.sv
/* combinational decode of the instruction register
   branches resolve from the ALU zero flag in the same cycle
   unknown opcodes act as adds that write rt */
`include "cpu_defs.svh"

module control_unit (
   input  logic [`CPU_WORD-1:0]         instr,
   input  logic                         zeroflag,
   output cpu_types_pkg::instr_fields_t fields,
   output cpu_types_pkg::ctrl_t         ctrl
);
   import cpu_types_pkg::*;

   opcode_t op;
   funct_t  funct;
   logic    is_rtype;
   logic    is_jr;

   // field split
   assign op           = opcode_t'(instr[31:26]);
   assign funct        = funct_t'(instr[5:0]);
   assign fields.rs    = instr[25:21];
   assign fields.rt    = instr[20:16];
   assign fields.rd    = instr[15:11];
   assign fields.shamt = instr[10:6];
   assign fields.imm16 = instr[15:0];

   assign is_rtype = (op == RTYPE);
   assign is_jr    = is_rtype && (funct == JR);

   always_comb begin
      ctrl = '0;

      ctrl.regdst   = ~is_rtype;                                      // i-type writes rt
      ctrl.extop    = ~(op == ORI || op == ANDI || op == XORI || op == LUI);
      ctrl.memwr    = (op == SW);
      ctrl.memtoreg = (op == LW);
      ctrl.is_mem   = (op == LW) || (op == SW);
      ctrl.link     = (op == JAL);                                    // r31 <- pc+4
      ctrl.halt     = (op == HALT);
      ctrl.jr       = is_jr;

      // everything writes except stores, branches, plain jumps, sc, halt, jr
      ctrl.regwr = ~(op == SW || op == BEQ || op == BNE || op == SC ||
                     op == J || op == HALT) && ~is_jr;

      // alu b source
      case (op)
         ADDIU, SLTI, SLTIU, ANDI, ORI, XORI, LW, SW, LL, SC: ctrl.alu_src = 2'd1;
         LUI:     ctrl.alu_src = 2'd2;
         default: ctrl.alu_src = 2'd0; // r-type and branches compare rt
      endcase

      // next pc select
      case (op)
         J, JAL:  ctrl.pc_src = 2'd2;
         BEQ:     ctrl.pc_src = {1'b0, zeroflag};
         BNE:     ctrl.pc_src = {1'b0, ~zeroflag};
         RTYPE:   ctrl.pc_src = is_jr ? 2'd2 : 2'd0; // jr rides the jump path
         default: ctrl.pc_src = 2'd0;
      endcase

      // alu operation
      ctrl.alu_op = ALU_ADD;
      if (is_rtype) begin
         case (funct)
            ADD, ADDU: ctrl.alu_op = ALU_ADD;
            SUB, SUBU: ctrl.alu_op = ALU_SUB; // no overflow trap
            AND:       ctrl.alu_op = ALU_AND;
            OR:        ctrl.alu_op = ALU_OR;
            XOR:       ctrl.alu_op = ALU_XOR;
            NOR:       ctrl.alu_op = ALU_NOR;
            SLL:       ctrl.alu_op = ALU_SLL;
            SRL:       ctrl.alu_op = ALU_SRL;
            SLT:       ctrl.alu_op = ALU_SLT;
            SLTU:      ctrl.alu_op = ALU_SLTU;
            default:   ctrl.alu_op = ALU_ADD;
         endcase
      end else begin
         case (op)
            ANDI:     ctrl.alu_op = ALU_AND;
            ORI:      ctrl.alu_op = ALU_OR;
            XORI:     ctrl.alu_op = ALU_XOR;
            SLTI:     ctrl.alu_op = ALU_SLT;
            SLTIU:    ctrl.alu_op = ALU_SLTU;
            BEQ, BNE: ctrl.alu_op = ALU_SUB;  // zero flag means equal
            default:  ctrl.alu_op = ALU_ADD;  // addiu, lw, sw, lui
         endcase
      end
   end

endmodule

//--- hw/cpu_fsm.sv
/* multicycle sequencer, one instruction in flight
   no strobes until the first clock after rst is released
   HALTED is left only through rst */
module cpu_fsm (
   input  logic                      CLK,
   input  logic                      rst,
   input  cpu_types_pkg::ctrl_t      ctrl,
   output cpu_types_pkg::cpu_state_t state,
   output logic                      ir_load,
   output logic                      pc_load,
   output logic                      wb_en,
   output logic                      mem_phase,
   output logic                      halt
);
   import cpu_types_pkg::*;

   cpu_state_t next_state;
   logic       running; // low through rst and one clock after

   always_ff @(posedge CLK) begin
      if (rst) begin
         state   <= FETCH;
         running <= 1'b0;
      end else begin
         state   <= next_state;
         running <= 1'b1;
      end
   end

   always_comb begin
      next_state = state;
      ir_load    = 1'b0;
      pc_load    = 1'b0;
      wb_en      = 1'b0;
      mem_phase  = 1'b0;
      halt       = 1'b0;
      case (state)
         FETCH: begin
            if (running) begin
               ir_load    = 1'b1; // iren, ir captures at edge
               next_state = EXEC;
            end
         end
         EXEC: begin
            if (ctrl.halt) begin
               next_state = HALTED;
            end else if (ctrl.is_mem) begin
               next_state = MEM;
            end else begin
               pc_load    = 1'b1;
               wb_en      = ctrl.regwr;
               next_state = FETCH;
            end
         end
         MEM: begin
            mem_phase  = 1'b1;        // ren or wen this cycle
            pc_load    = 1'b1;
            wb_en      = ctrl.regwr;  // lw writeback
            next_state = FETCH;
         end
         HALTED: halt = 1'b1;
         default: next_state = FETCH;
      endcase
   end

endmodule

//--- hw/pc_counter.sv
/* program counter, updates only on pc_load
   branch offset arrives sign-extended in words
   jump keeps pc[31:28] of the current instruction */
`include "cpu_defs.svh"

module pc_counter (
   input  logic                 CLK,
   input  logic                 rst,
   input  logic                 pc_load,
   input  logic [1:0]           pc_src,
   input  logic                 jr,
   input  logic [`CPU_WORD-1:0] offset,
   input  logic [25:0]          target,
   input  logic [`CPU_WORD-1:0] rs_value,
   output logic [`CPU_WORD-1:0] pc,
   output logic [`CPU_WORD-1:0] pc_next_seq
);
   logic [`CPU_WORD-1:0] pc_branch;
   logic [`CPU_WORD-1:0] pc_new;

   assign pc_next_seq = pc + `PC_STEP;               // also the jal link value
   assign pc_branch   = pc_next_seq + (offset << 2);

   always_comb begin
      case (pc_src)
         2'd1: pc_new = pc_branch;
         2'd2: begin
            if (jr)
               pc_new = rs_value;
            else
               pc_new = {pc[`CPU_WORD-1:28], target, 2'b00};
         end
         default: pc_new = pc_next_seq;
      endcase
   end

   always_ff @(posedge CLK) begin
      if (rst)
         pc <= `RESET_PC;
      else if (pc_load)
         pc <= pc_new;
   end

endmodule

//--- hw/register_file.sv
/* two async read ports, one sync write port
   writes to r0 are dropped so it always reads zero
   rst clears every register */
`include "cpu_defs.svh"

module register_file (
   input  logic                   CLK,
   input  logic                   rst,
   input  logic                   wen,
   input  cpu_types_pkg::regbits_t waddr,
   input  logic [`CPU_WORD-1:0]   wdata,
   input  cpu_types_pkg::regbits_t raddr1,
   input  cpu_types_pkg::regbits_t raddr2,
   output logic [`CPU_WORD-1:0]   rdata1,
   output logic [`CPU_WORD-1:0]   rdata2
);
   logic [`CPU_WORD-1:0] regs [`REG_COUNT];

   always_ff @(posedge CLK) begin
      if (rst) begin
         for (int i = 0; i < `REG_COUNT; i++)
            regs[i] <= '0;
      end else if (wen && (waddr != '0)) begin
         regs[waddr] <= wdata;
      end
   end

   assign rdata1 = regs[raddr1]; // read old value on same-cycle write
   assign rdata2 = regs[raddr2];

endmodule

//--- hw/alu.sv
/* integer ALU, no overflow detection
   shifts operate on b by shamt, logical only
   SLT is signed, SLTU unsigned */
`include "cpu_defs.svh"

module alu (
   input  cpu_types_pkg::alu_op_t op,
   input  logic [`CPU_WORD-1:0]   a,
   input  logic [`CPU_WORD-1:0]   b,
   input  logic [4:0]             shamt,
   output logic [`CPU_WORD-1:0]   result,
   output logic                   zero
);
   import cpu_types_pkg::*;

   logic lt_signed;
   logic lt_unsigned;

   assign lt_signed   = $signed(a) < $signed(b);
   assign lt_unsigned = a < b;

   always_comb begin
      case (op)
         ALU_ADD:  result = a + b;
         ALU_SUB:  result = a - b;
         ALU_AND:  result = a & b;
         ALU_OR:   result = a | b;
         ALU_XOR:  result = a ^ b;
         ALU_NOR:  result = ~(a | b);
         ALU_SLL:  result = b << shamt;  // rt shifted, rs ignored
         ALU_SRL:  result = b >> shamt;
         ALU_SLT:  result = {{(`CPU_WORD-1){1'b0}}, lt_signed};
         ALU_SLTU: result = {{(`CPU_WORD-1){1'b0}}, lt_unsigned};
         default:  result = '0;
      endcase
   end

   assign zero = (result == '0); // beq/bne equality

endmodule

//--- hw/cpu_core.sv
/* multicycle core top, 2 cycles per instruction, 3 for lw/sw
   both memory ports must answer combinationally, no stalls
   halt stays high until rst */
`include "cpu_defs.svh"

module cpu_core (
   input  logic                     CLK,
   input  logic                     rst,
   output logic [`CPU_WORD-1:0]     iaddr,
   output logic                     iren,
   input  logic [`CPU_WORD-1:0]     instr,
   output cpu_types_pkg::dmem_req_t dmem,
   input  logic [`CPU_WORD-1:0]     drdata,
   output logic                     halt
);
   import cpu_types_pkg::*;

   logic [`CPU_WORD-1:0] ir;          // instruction register
   instr_fields_t        fields;
   ctrl_t                ctrl;
   cpu_state_t           state;
   logic                 ir_load;
   logic                 pc_load;
   logic                 wb_en;
   logic                 mem_phase;
   logic [`CPU_WORD-1:0] pc;
   logic [`CPU_WORD-1:0] pc_next_seq;
   logic [`CPU_WORD-1:0] rdata1;
   logic [`CPU_WORD-1:0] rdata2;
   logic [`CPU_WORD-1:0] ext_imm;
   logic [`CPU_WORD-1:0] branch_off;
   logic [`CPU_WORD-1:0] alu_a;
   logic [`CPU_WORD-1:0] alu_b;
   logic [`CPU_WORD-1:0] alu_result;
   logic                 alu_zero;
   regbits_t             wr_reg;
   logic [`CPU_WORD-1:0] wr_data;

   always_ff @(posedge CLK) begin
      if (ir_load)
         ir <= instr;
   end

   control_unit u_ctrl (.instr(ir), .zeroflag(alu_zero), .fields(fields), .ctrl(ctrl));

   cpu_fsm u_fsm (
      .CLK(CLK), .rst(rst), .ctrl(ctrl), .state(state), .ir_load(ir_load),
      .pc_load(pc_load), .wb_en(wb_en), .mem_phase(mem_phase), .halt(halt)
   );

   // immediate extender
   assign ext_imm    = ctrl.extop ? {{16{fields.imm16[15]}}, fields.imm16}
                                  : {16'b0, fields.imm16};
   assign branch_off = {{16{fields.imm16[15]}}, fields.imm16}; // always signed

   pc_counter u_pc (
      .CLK(CLK), .rst(rst), .pc_load(pc_load), .pc_src(ctrl.pc_src), .jr(ctrl.jr),
      .offset(branch_off), .target(ir[25:0]), .rs_value(rdata1),
      .pc(pc), .pc_next_seq(pc_next_seq)
   );

   register_file u_rf (
      .CLK(CLK), .rst(rst), .wen(wb_en), .waddr(wr_reg), .wdata(wr_data),
      .raddr1(fields.rs), .raddr2(fields.rt), .rdata1(rdata1), .rdata2(rdata2)
   );

   // alu operand muxes, lui ignores rs
   always_comb begin
      case (ctrl.alu_src)
         2'd1:    alu_b = ext_imm;
         2'd2:    alu_b = {fields.imm16, 16'b0};
         default: alu_b = rdata2;
      endcase
   end
   assign alu_a = (ctrl.alu_src == 2'd2) ? '0 : rdata1;

   alu u_alu (
      .op(ctrl.alu_op), .a(alu_a), .b(alu_b), .shamt(fields.shamt),
      .result(alu_result), .zero(alu_zero)
   );

   // destination: r31 for jal, else rt or rd
   assign wr_reg  = ctrl.link ? regbits_t'(`REG_COUNT - 1)
                              : (ctrl.regdst ? fields.rt : fields.rd);
   assign wr_data = ctrl.memtoreg ? drdata
                                  : (ctrl.link ? pc_next_seq : alu_result);

   assign iaddr = pc;
   assign iren  = ir_load;

   // data port, strobes only in MEM
   assign dmem.addr  = alu_result;    // base + offset
   assign dmem.wdata = rdata2;
   assign dmem.ren   = mem_phase & ctrl.memtoreg;
   assign dmem.wen   = mem_phase & ctrl.memwr;

endmodule

//--- verification/cpu_chk.sv
/* concurrent checks on the core strobes, attached to cpu_core by bind
   state is the sequencer state inside the core */
module cpu_chk (
   input logic                      CLK,
   input logic                      rst,
   input logic                      iren,
   input cpu_types_pkg::dmem_req_t  dmem,
   input logic                      halt,
   input cpu_types_pkg::cpu_state_t state
);
   import cpu_types_pkg::*;

   // one data strobe at a time
   a_rw_exclusive: assert property (@(posedge CLK) !(dmem.ren && dmem.wen))
      else $error("data read and write strobes high together");

   a_iren_fetch: assert property (@(posedge CLK) iren |-> state == FETCH)
      else $error("instruction fetch outside FETCH");

   // only rst leaves HALTED
   a_halt_sticky: assert property (@(posedge CLK) disable iff (rst) halt |=> halt)
      else $error("halt dropped without reset");

   a_rst_quiet: assert property (@(posedge CLK) rst |-> !(iren || dmem.ren || dmem.wen || halt))
      else $error("strobe or halt active during reset");

endmodule

bind cpu_core cpu_chk chk (
   .CLK(CLK), .rst(rst), .iren(iren), .dmem(dmem), .halt(halt), .state(state)
);

//--- verification/cpu_tb.sv
/* self-checking testbench for cpu_core driven by a random program from a fixed seed
   every store is compared in order against an ISA model in this file
   imem and dram are 256 words each and answer combinationally
   dram read data is valid only while ren is high */
`include "cpu_defs.svh"

module cpu_tb;
   import cpu_types_pkg::*;

   localparam int body_len  = 60;     // random part before the dump tail
   localparam int mem_words = 256;
   localparam int dump_base = 'h200;  // byte address of the register dump
   localparam int halt_wait = 5000;
   localparam funct_t  r_ops [12] = '{ADD, ADDU, SUB, SUBU, AND, OR, XOR, NOR,
                                      SLL, SRL, SLT, SLTU};
   localparam opcode_t i_ops [7]  = '{ADDIU, ANDI, ORI, XORI, SLTI, SLTIU, LUI};

   logic                 CLK;
   logic                 rst;
   logic [`CPU_WORD-1:0] iaddr;
   logic                 iren;
   logic [`CPU_WORD-1:0] instr;
   dmem_req_t            dmem;
   logic [`CPU_WORD-1:0] drdata;
   logic                 halt;
   logic [`CPU_WORD-1:0] imem [mem_words];
   logic [`CPU_WORD-1:0] dram [mem_words];
   integer               seed;
   dmem_write_t          exp_writes [$];  // model store trace
   int                   n_writes = 0;
   dmem_write_t          seen;

   cpu_core uut (
      .CLK(CLK), .rst(rst), .iaddr(iaddr), .iren(iren), .instr(instr),
      .dmem(dmem), .drdata(drdata), .halt(halt)
   );

   always #4 CLK = ~CLK;

   assign instr  = imem[iaddr[9:2]];      // word indexed without wait states
   assign drdata = dmem.ren ? dram[dmem.addr[9:2]] : '0;  // read data only under ren

   always @(posedge CLK) begin
      if (rst) begin
         for (int i = 0; i < mem_words; i++)
            dram[i] <= fill_word(i);      // same fill the model starts from
      end else if (dmem.wen) begin
         dram[dmem.addr[9:2]] <= dmem.wdata;
      end
   end

   // stores sampled mid-cycle where strobes are settled
   always @(negedge CLK) begin
      if (!rst && dmem.wen) begin
         seen.addr = dmem.addr;
         seen.data = dmem.wdata;
         check_write(seen);
         n_writes++;
      end
   end

   function automatic logic [`CPU_WORD-1:0] fill_word(int i);
      return (32'(i) * 32'h9e37_79b9) ^ 32'h5bd1_e995;
   endfunction

   function automatic logic [31:0] random_word();
      logic [31:0] v;
      v = $random(seed);
      return v;
   endfunction

   function automatic int pick_below(int n);
      logic [31:0] v;
      v = $random(seed);
      return int'(v % 32'(n));
   endfunction

   function automatic logic [31:0] rtype_word(funct_t fn, logic [4:0] rs, logic [4:0] rt,
                                              logic [4:0] rd, logic [4:0] sh);
      return {RTYPE, rs, rt, rd, sh, fn};
   endfunction

   function automatic logic [31:0] itype_word(opcode_t op, logic [4:0] rs, logic [4:0] rt,
                                              logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic logic [31:0] jtype_word(opcode_t op, logic [25:0] tgt);
      return {op, tgt};
   endfunction

   task automatic abort_run(string why);
      $display("%s", why);
      $display("Test FAILED");
      $fatal(1, "simulation stopped on first error");
   endtask

   task automatic check_write(dmem_write_t got);
      dmem_write_t exp;
      if (n_writes >= exp_writes.size()) begin
         abort_run($sformatf("Mismatch at %0t: extra store addr %h data %h, model has %0d",
                             $time, got.addr, got.data, exp_writes.size()));
      end else begin
         exp = exp_writes[n_writes];
         if (got !== exp)
            abort_run($sformatf("Mismatch at %0t: store %0d addr %h data %h, expected %h %h",
                                $time, n_writes, got.addr, got.data, exp.addr, exp.data));
      end
   endtask

   task automatic check_halt(logic got, logic exp, string when);
      if (got !== exp)
         abort_run($sformatf("Mismatch at %0t: halt %b %s, expected %b", $time, got, when, exp));
   endtask

   task automatic check_word(logic [`CPU_WORD-1:0] got, logic [`CPU_WORD-1:0] exp, string what);
      if (got !== exp)
         abort_run($sformatf("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp));
   endtask

   task automatic check_quiet(dmem_req_t req, logic fetch, string when);
      if ({fetch, req.ren, req.wen} !== 3'b000)
         abort_run($sformatf("Mismatch at %0t: iren/ren/wen %b%b%b %s, expected 000",
                             $time, fetch, req.ren, req.wen, when));
   endtask

   task automatic build_program();
      int          idx;
      int          kind;
      int          tgt;
      int          skip_until;  // furthest forward target so far
      logic [4:0]  d;
      logic [4:0]  s;
      logic [4:0]  t;
      logic [15:0] imm;
      for (int i = 0; i < mem_words; i++)
         imem[i] = {HALT, 26'(i)};       // stray fetch halts
      idx = 0;
      skip_until = 0;
      while (idx < body_len) begin
         kind = pick_below(12);
         d    = 5'(pick_below(26));      // r0 destinations must be dropped
         s    = 5'(pick_below(26));
         t    = 5'(pick_below(26));
         imm  = 16'(random_word());
         tgt  = idx + 1 + pick_below(4);
         if (tgt > body_len)
            tgt = body_len;
         if (kind == 11 && idx >= skip_until && idx + 2 < body_len) begin
            // no branch lands between the ori and the jr
            tgt = idx + 2 + pick_below(3);
            if (tgt > body_len)
               tgt = body_len;
            imem[idx]     = itype_word(ORI, 5'd0, 5'd26, 16'(tgt * 4));
            imem[idx + 1] = rtype_word(JR, 5'd26, 5'd0, 5'd0, 5'd0);
            skip_until    = tgt;
            idx += 2;
         end else begin
            if (kind >= 9) begin
               if (kind == 9)
                  imem[idx] = itype_word(pick_below(2) != 0 ? BEQ : BNE, s, t,
                                         16'(tgt - idx - 1));
               else
                  imem[idx] = jtype_word(pick_below(2) != 0 ? J : JAL, 26'(tgt));
               if (tgt > skip_until)
                  skip_until = tgt;
            end else if (kind >= 7) begin
               imem[idx] = itype_word(kind == 7 ? LW : SW, 5'd0, 5'(1 + pick_below(25)),
                                      16'(4 * pick_below(64)));  // 64-word region
            end else if (kind >= 4) begin
               imem[idx] = itype_word(i_ops[pick_below(7)], s, d, imm);
            end else begin
               imem[idx] = rtype_word(r_ops[pick_below(12)], s, t, d, 5'(pick_below(32)));
            end
            idx++;
         end
      end
      for (int n = 1; n < `REG_COUNT; n++)
         imem[body_len + n - 1] = itype_word(SW, 5'd0, 5'(n), 16'(dump_base + 4 * n));
      imem[body_len + `REG_COUNT - 1] = {HALT, 26'd0};
   endtask

   // ISA model fills exp_writes in program order
   task automatic run_model();
      logic [`CPU_WORD-1:0] r [`REG_COUNT];
      logic [`CPU_WORD-1:0] mm [mem_words];
      logic [`CPU_WORD-1:0] pc;
      logic [`CPU_WORD-1:0] ins;
      logic [`CPU_WORD-1:0] a;
      logic [`CPU_WORD-1:0] b;
      logic [`CPU_WORD-1:0] simm;
      logic [`CPU_WORD-1:0] ea;
      logic [`CPU_WORD-1:0] val;
      logic [`CPU_WORD-1:0] nxt;
      logic [4:0]           dst;
      logic                 we;
      int                   steps;
      dmem_write_t          w;
      for (int i = 0; i < `REG_COUNT; i++)
         r[i] = '0;
      for (int i = 0; i < mem_words; i++)
         mm[i] = fill_word(i);
      pc    = `RESET_PC;
      steps = 0;
      ins   = imem[pc[9:2]];
      while (opcode_t'(ins[31:26]) != HALT && steps < 2000) begin
         a    = r[ins[25:21]];
         b    = r[ins[20:16]];
         simm = {{16{ins[15]}}, ins[15:0]};
         ea   = a + simm;
         nxt  = pc + `PC_STEP;
         dst  = ins[20:16];   // i-type target
         we   = 1'b0;
         val  = '0;
         case (opcode_t'(ins[31:26]))
            RTYPE: begin
               dst = ins[15:11];
               we  = 1'b1;
               case (funct_t'(ins[5:0]))
                  ADD, ADDU: val = a + b;
                  SUB, SUBU: val = a - b;
                  AND:       val = a & b;
                  OR:        val = a | b;
                  XOR:       val = a ^ b;
                  NOR:       val = ~(a | b);
                  SLL:       val = b << ins[10:6];
                  SRL:       val = b >> ins[10:6];
                  SLT:       val = {31'b0, $signed(a) < $signed(b)};
                  SLTU:      val = {31'b0, a < b};
                  JR: begin
                     nxt = a;
                     we  = 1'b0;
                  end
                  default:   we = 1'b0;
               endcase
            end
            ADDIU: {we, val} = {1'b1, a + simm};
            ANDI:  {we, val} = {1'b1, a & {16'b0, ins[15:0]}};
            ORI:   {we, val} = {1'b1, a | {16'b0, ins[15:0]}};
            XORI:  {we, val} = {1'b1, a ^ {16'b0, ins[15:0]}};
            SLTI:  {we, val} = {1'b1, 31'b0, $signed(a) < $signed(simm)};
            SLTIU: {we, val} = {1'b1, 31'b0, a < simm};  // sign-extended imm in unsigned compare
            LUI:   {we, val} = {1'b1, ins[15:0], 16'b0};
            LW:    {we, val} = {1'b1, mm[ea[9:2]]};
            SW: begin
               mm[ea[9:2]] = b;
               w.addr = ea;
               w.data = b;
               exp_writes.push_back(w);
            end
            BEQ:   if (a == b) nxt = nxt + (simm << 2);
            BNE:   if (a != b) nxt = nxt + (simm << 2);
            J:     nxt = {pc[31:28], ins[25:0], 2'b00};
            JAL: begin
               {we, dst, val} = {1'b1, 5'd31, nxt};   // link is pc + 4
               nxt = {pc[31:28], ins[25:0], 2'b00};
            end
            default: we = 1'b0;
         endcase
         if (we && dst != 5'd0)
            r[dst] = val;
         pc  = nxt;
         ins = imem[pc[9:2]];
         steps++;
      end
      if (steps >= 2000)
         abort_run("model did not reach HALT within 2000 instructions, program is broken");
   endtask

   initial begin
      int cycles;
      seed = 32'h1d5e3a53;
      CLK  = 1'b0;
      rst  = 1'b1;
      build_program();
      run_model();
      repeat (16) begin
         @(negedge CLK);
         check_quiet(dmem, iren, "during reset");
         check_halt(halt, 1'b0, "during reset");
      end
      rst = 1'b0;
      cycles = 0;
      while (!iren && cycles < 10) begin
         @(negedge CLK);
         cycles++;
      end
      if (!iren)
         abort_run("no instruction fetch within 10 cycles after reset release");
      check_word(iaddr, `RESET_PC, "first fetch address");
      cycles = 0;
      while (!halt && cycles < halt_wait) begin
         @(negedge CLK);
         cycles++;
      end
      if (!halt)
         abort_run("halt did not rise within 5000 cycles after reset");
      check_word(32'(n_writes), 32'(exp_writes.size()), "store count at halt");
      repeat (20) begin
         @(negedge CLK);
         check_halt(halt, 1'b1, "after halt");
         check_quiet(dmem, iren, "after halt");
      end
      $display("Test OK");
      $finish;
   end

endmodule

//--- files.f
+incdir+hw
hw/cpu_types_pkg.sv
hw/control_unit.sv
hw/cpu_fsm.sv
hw/pc_counter.sv
hw/register_file.sv
hw/alu.sv
hw/cpu_core.sv
verification/cpu_chk.sv
verification/cpu_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the core testbench with Verilator, run it, and look for the pass line

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -j 0 --top-module cpu_tb \
   -f files.f -Mdir obj_dir -o cpu_tb_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
   cat build.log
   echo "verilator build failed with status $status"
   exit 1
fi

./obj_dir/cpu_tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qx "Test OK" sim.log; then
   exit 0
fi
echo "pass line not found in sim.log"
exit 1
